//--- vlog.f
+incdir+common
common/pe_ctrl_pkg.sv
common/pe_arith_pkg.sv
common/pe_unit_if.sv
logic/pe_delay_line.sv
pe/mod_addsub_unit.sv
pe/mod_mul_reduce.sv
pe/pe_lane.sv
pe/pe_array_top.sv
testbench/pe_array_props.sv
testbench/pe_array_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the PE array testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module pe_array_tb -Mdir obj_dir -o pe_array_sim \
    && ./obj_dir/pe_array_sim > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx '\*\* PASS \*\*' sim.log && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }

//--- testbench/pe_array_tb.sv
// --------------------
// PE array testbench
// --------------------
`include "pe_settings.svh"
`timescale 1ns/10ps

module pe_array_tb;

    localparam longint unsigned KEM_Q       = 3329;
    localparam longint unsigned DSA_Q       = 8380417;
    localparam int              W           = `PE_WIDTH;
    localparam int              DRAIN_LIMIT = 40;
    localparam int              STREAM_LEN  = 32;

    logic                   clk;
    logic                   rst;
    pe_ctrl_pkg::pe_alg_t   alg;
    pe_ctrl_pkg::pe_instr_t instr;
    pe_arith_pkg::coeff_t   data_in  [0:`PE_NUM-1][0:`PE_IN_NUM-1];
    pe_arith_pkg::coeff_t   data_out [0:`PE_NUM-1][0:`PE_OUT_NUM-1];

    int seed;
    int cyc;
    int checks;
    int test_errors;
    int total_errors;
    int tests_run;
    int tests_failed;

    // One pending expectation per lane and due cycle
    int                   exp_due  [$];
    int                   exp_lane [$];
    pe_arith_pkg::coeff_t exp_out0 [$];
    pe_arith_pkg::coeff_t exp_out1 [$];

    pe_array_top uut (
        .clk      (clk),
        .rst      (rst),
        .alg      (alg),
        .instr    (instr),
        .data_in  (data_in),
        .data_out (data_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Counts rising edges seen so far
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic longint unsigned q_of(input pe_ctrl_pkg::pe_alg_t a);
        if (a == pe_ctrl_pkg::DSA_44 || a == pe_ctrl_pkg::DSA_65 || a == pe_ctrl_pkg::DSA_87) begin
            return DSA_Q;
        end
        return KEM_Q;
    endfunction

    function automatic int latency_of(input pe_ctrl_pkg::pe_instr_t op);
        case (op)
            pe_ctrl_pkg::MADD, pe_ctrl_pkg::MSUB: begin
                return pe_ctrl_pkg::ADDSUB_LAT;
            end
            pe_ctrl_pkg::MMUL: begin
                return pe_ctrl_pkg::MUL_LAT;
            end
            default: begin
                return pe_ctrl_pkg::BFO_LAT;
            end
        endcase
    endfunction

    // Expected {out0, out1} from the instruction rules
    function automatic logic [2*W-1:0] ref_result(
        input pe_ctrl_pkg::pe_instr_t op,
        input pe_ctrl_pkg::pe_alg_t   a,
        input longint unsigned        x0,
        input longint unsigned        x1,
        input longint unsigned        x2
    );
        longint unsigned q;
        longint unsigned t;
        longint unsigned r0;
        longint unsigned r1;
        q  = q_of(a);
        r0 = 0;
        r1 = 0;
        case (op)
            pe_ctrl_pkg::MADD: begin
                r0 = (x0 + x1) % q;
            end
            pe_ctrl_pkg::MSUB: begin
                r0 = (x0 + q - x1) % q;
            end
            pe_ctrl_pkg::MMUL: begin
                r0 = (x0 * x1) % q;
            end
            pe_ctrl_pkg::CT_BFO: begin
                t  = (x1 * x2) % q;
                r0 = (x0 + t) % q;
                r1 = (x0 + q - t) % q;
            end
            pe_ctrl_pkg::GS_BFO: begin
                r0 = (x0 + x1) % q;
                r1 = (((x0 + q - x1) % q) * x2) % q;
            end
            default: begin
            end
        endcase
        return {r0[W-1:0], r1[W-1:0]};
    endfunction

    // Biased towards 0 and values near q so sums wrap and differences borrow
    function automatic pe_arith_pkg::coeff_t pick_operand(input longint unsigned q);
        int unsigned r;
        r = $unsigned($random(seed));
        case (r[2:0])
            3'd0: begin
                return pe_arith_pkg::coeff_t'(q - 1);
            end
            3'd1: begin
                return '0;
            end
            3'd2: begin
                return pe_arith_pkg::coeff_t'(q - 1 - r[15:8]);
            end
            default: begin
                return pe_arith_pkg::coeff_t'((r >> 3) % q);
            end
        endcase
    endfunction

    task automatic drive_one(
        input pe_ctrl_pkg::pe_instr_t op,
        input pe_ctrl_pkg::pe_alg_t   a,
        input bit                     checked,
        input bit                     corner
    );
        longint unsigned      q;
        logic [2*W-1:0]       r;
        pe_arith_pkg::coeff_t v [0:`PE_IN_NUM-1];
        q = q_of(a);
        @(posedge clk);
        #2;
        instr = op;
        alg   = a;
        for (int l = 0; l < `PE_NUM; l++) begin
            for (int p = 0; p < `PE_IN_NUM; p++) begin
                if (corner) begin
                    // Odd lanes borrow on 0 - (q-1)
                    v[p] = (p == 0 && l[0]) ? '0 : pe_arith_pkg::coeff_t'(q - 1);
                end else begin
                    v[p] = pick_operand(q);
                end
                data_in[l][p] = v[p];
            end
            if (checked) begin
                r = ref_result(op, a, v[0], v[1], v[2]);
                exp_due.push_back(cyc + latency_of(op));
                exp_lane.push_back(l);
                exp_out0.push_back(r[2*W-1:W]);
                exp_out1.push_back(r[W-1:0]);
            end
        end
    endtask

    task automatic end_run(input bit timed_out);
        $display("Tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, total_errors);
        if (!timed_out && total_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_due.size() > 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_due.size() > 0) begin
            $display("Timeout: %0d expected results never came due", exp_due.size());
            end_run(1'b1);
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic run_stream(
        input string                  name,
        input pe_ctrl_pkg::pe_instr_t op,
        input pe_ctrl_pkg::pe_alg_t   a
    );
        drive_one(op, a, 1'b1, 1'b1);
        for (int i = 0; i < STREAM_LEN; i++) begin
            drive_one(op, a, 1'b1, 1'b0);
        end
        wait_drain();
        end_test(name);
    endtask

    always @(negedge clk) begin : compare
        int                   lane;
        pe_arith_pkg::coeff_t e0;
        pe_arith_pkg::coeff_t e1;
        while (exp_due.size() > 0 && exp_due[0] == cyc) begin
            void'(exp_due.pop_front());
            lane = exp_lane.pop_front();
            e0   = exp_out0.pop_front();
            e1   = exp_out1.pop_front();
            checks++;
            assert (data_out[lane][0] === e0) else begin
                $display("FAILED t=%0t data_out[%0d][0] got %0d expected %0d",
                         $time, lane, data_out[lane][0], e0);
                test_errors++;
                total_errors++;
            end
            assert (data_out[lane][1] === e1) else begin
                $display("FAILED t=%0t data_out[%0d][1] got %0d expected %0d",
                         $time, lane, data_out[lane][1], e1);
                test_errors++;
                total_errors++;
            end
        end
    end

    initial begin : main
        seed         = 40715;
        cyc          = 0;
        checks       = 0;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst          = 1'b1;
        alg          = pe_ctrl_pkg::KEM_512;
        instr        = pe_ctrl_pkg::GS_BFO;
        // Nonzero operands during reset, so any uncleared stage shows up
        for (int l = 0; l < `PE_NUM; l++) begin
            for (int p = 0; p < `PE_IN_NUM; p++) begin
                data_in[l][p] = pe_arith_pkg::coeff_t'(3 * l + p + 1);
            end
        end
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        // First GS result reaches data_out only BFO_LAT edges after release
        repeat (pe_ctrl_pkg::BFO_LAT) begin
            @(negedge clk);
            for (int l = 0; l < `PE_NUM; l++) begin
                for (int p = 0; p < `PE_OUT_NUM; p++) begin
                    checks++;
                    assert (data_out[l][p] === '0) else begin
                        $display("FAILED t=%0t data_out[%0d][%0d] got %0d expected 0",
                                 $time, l, p, data_out[l][p]);
                        test_errors++;
                        total_errors++;
                    end
                end
            end
        end
        end_test("reset clears outputs");

        run_stream("MADD KEM_768", pe_ctrl_pkg::MADD, pe_ctrl_pkg::KEM_768);
        run_stream("MSUB KEM_768", pe_ctrl_pkg::MSUB, pe_ctrl_pkg::KEM_768);
        run_stream("MADD DSA_65", pe_ctrl_pkg::MADD, pe_ctrl_pkg::DSA_65);
        run_stream("MSUB DSA_65", pe_ctrl_pkg::MSUB, pe_ctrl_pkg::DSA_65);
        run_stream("MMUL KEM_512", pe_ctrl_pkg::MMUL, pe_ctrl_pkg::KEM_512);
        run_stream("MMUL DSA_44", pe_ctrl_pkg::MMUL, pe_ctrl_pkg::DSA_44);
        run_stream("CT_BFO KEM_768", pe_ctrl_pkg::CT_BFO, pe_ctrl_pkg::KEM_768);
        run_stream("CT_BFO DSA_65", pe_ctrl_pkg::CT_BFO, pe_ctrl_pkg::DSA_65);
        run_stream("GS_BFO KEM_1024", pe_ctrl_pkg::GS_BFO, pe_ctrl_pkg::KEM_1024);
        run_stream("GS_BFO DSA_87", pe_ctrl_pkg::GS_BFO, pe_ctrl_pkg::DSA_87);

        // Results straddling the modulus change are left unchecked
        for (int i = 0; i < 12; i++) begin
            drive_one(pe_ctrl_pkg::CT_BFO, pe_ctrl_pkg::KEM_512,
                      i < 12 - (pe_ctrl_pkg::BFO_LAT - 1), 1'b0);
        end
        for (int i = 0; i < 16; i++) begin
            drive_one(pe_ctrl_pkg::CT_BFO, pe_ctrl_pkg::DSA_87,
                      i >= pe_ctrl_pkg::BFO_LAT, 1'b0);
        end
        wait_drain();
        end_test("alg switch KEM_512 to DSA_87");

        end_run(1'b0);
    end

endmodule

//--- testbench/pe_array_props.sv
// --------------------
// PE lane checks
// --------------------
`timescale 1ns/10ps

module pe_array_props (
    input logic                 clk,
    input logic                 rst,
    input pe_ctrl_pkg::pe_alg_t alg,
    input pe_arith_pkg::coeff_t sum,
    input pe_arith_pkg::coeff_t diff,
    input pe_arith_pkg::coeff_t prod,
    input pe_arith_pkg::coeff_t out0,
    input pe_arith_pkg::coeff_t out1
);

    // Pipeline still holds data of the old modulus
    localparam int SETTLE = 2 * pe_ctrl_pkg::BFO_LAT;

    pe_ctrl_pkg::pe_alg_t alg_q;
    int                   settle_cnt;
    pe_arith_pkg::coeff_t q;
    logic                 quiet;

    assign q     = pe_arith_pkg::modulus_of(alg);
    assign quiet = (settle_cnt == 0) && (alg == alg_q);

    always_ff @(posedge clk) begin
        if (rst || alg != alg_q) begin
            alg_q      <= alg;
            settle_cnt <= SETTLE;
        end else if (settle_cnt != 0) begin
            settle_cnt <= settle_cnt - 1;
        end
    end

    assert property (@(posedge clk) disable iff (rst || !quiet) (sum < q) && (diff < q))
        else $error("lane sum or difference not reduced below q");

    assert property (@(posedge clk) disable iff (rst || !quiet) prod < q)
        else $error("lane product not reduced below q");

    assert property (@(posedge clk) rst |=> (out0 == '0) && (out1 == '0))
        else $error("lane outputs not cleared by reset");

endmodule

bind pe_lane pe_array_props u_props (
    .clk  (clk),
    .rst  (rst),
    .alg  (alg),
    .sum  (u_if.sum),
    .diff (u_if.diff),
    .prod (u_if.prod),
    .out0 (out0),
    .out1 (out1)
);

//--- pe/pe_array_top.sv
// --------------------
// PE array top
// --------------------
`include "pe_settings.svh"
`timescale 1ns/10ps

module pe_array_top (
    input  logic                    clk,
    input  logic                    rst,
    input  pe_ctrl_pkg::pe_alg_t    alg,
    input  pe_ctrl_pkg::pe_instr_t  instr,
    input  pe_arith_pkg::coeff_t    data_in  [0:`PE_NUM-1][0:`PE_IN_NUM-1],
    output pe_arith_pkg::coeff_t    data_out [0:`PE_NUM-1][0:`PE_OUT_NUM-1]
);

    // One lane per coefficient, all sharing alg and instr
    for (genvar g = 0; g < `PE_NUM; g++) begin : g_lane
        pe_lane u_lane (
            .clk   (clk),
            .rst   (rst),
            .alg   (alg),
            .instr (instr),
            .in0   (data_in[g][0]),
            .in1   (data_in[g][1]),
            .in2   (data_in[g][2]),
            .out0  (data_out[g][0]),
            .out1  (data_out[g][1])
        );
    end

endmodule

//--- pe/pe_lane.sv
// --------------------
// PE lane routing
// --------------------
`timescale 1ns/10ps

module pe_lane (
    input  logic                    clk,
    input  logic                    rst,
    input  pe_ctrl_pkg::pe_alg_t    alg,
    input  pe_ctrl_pkg::pe_instr_t  instr,
    input  pe_arith_pkg::coeff_t    in0,
    input  pe_arith_pkg::coeff_t    in1,
    input  pe_arith_pkg::coeff_t    in2,
    output pe_arith_pkg::coeff_t    out0,
    output pe_arith_pkg::coeff_t    out1
);

    pe_arith_pkg::coeff_t a_d3;
    pe_arith_pkg::coeff_t w_d1;
    pe_arith_pkg::coeff_t sum_d3;

    pe_unit_if u_if ();

    mod_addsub_unit u_addsub (
        .clk (clk),
        .rst (rst),
        .u   (u_if)
    );

    mod_mul_reduce u_mul (
        .clk (clk),
        .rst (rst),
        .u   (u_if)
    );

    // CT: in0 waits for the product
    pe_delay_line #(.DEPTH(pe_ctrl_pkg::MUL_LAT)) a_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (in0),
        .dout (a_d3)
    );

    // GS: twiddle waits for the difference
    pe_delay_line #(.DEPTH(pe_ctrl_pkg::ADDSUB_LAT)) w_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (in2),
        .dout (w_d1)
    );

    // GS: sum waits for the twiddled difference
    pe_delay_line #(.DEPTH(pe_ctrl_pkg::BFO_LAT - pe_ctrl_pkg::ADDSUB_LAT)) sum_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (u_if.sum),
        .dout (sum_d3)
    );

    // Operand routing
    always_comb begin
        u_if.dsa   = pe_arith_pkg::is_dsa(alg);
        u_if.add_a = in0;
        u_if.add_b = in1;
        u_if.sub_a = in0;
        u_if.sub_b = in1;
        u_if.mul_a = in0;
        u_if.mul_b = in1;
        case (instr)
            pe_ctrl_pkg::CT_BFO: begin
                u_if.mul_a = in1;
                u_if.mul_b = in2;
                u_if.add_a = a_d3;
                u_if.add_b = u_if.prod;
                u_if.sub_a = a_d3;
                u_if.sub_b = u_if.prod;
            end
            pe_ctrl_pkg::GS_BFO: begin
                u_if.mul_a = u_if.diff;
                u_if.mul_b = w_d1;
            end
            default: begin
            end
        endcase
    end

    // Result selection
    always_comb begin
        out0 = '0;
        out1 = '0;
        case (instr)
            pe_ctrl_pkg::MADD: begin
                out0 = u_if.sum;
            end
            pe_ctrl_pkg::MSUB: begin
                out0 = u_if.diff;
            end
            pe_ctrl_pkg::MMUL: begin
                out0 = u_if.prod;
            end
            pe_ctrl_pkg::CT_BFO: begin
                out0 = u_if.sum;
                out1 = u_if.diff;
            end
            pe_ctrl_pkg::GS_BFO: begin
                out0 = sum_d3;
                out1 = u_if.prod;
            end
            default: begin
            end
        endcase
    end

endmodule

//--- pe/mod_mul_reduce.sv
// --------------------
// Modular multiplier
// --------------------
`include "pe_settings.svh"
`timescale 1ns/10ps

module mod_mul_reduce (
    input logic     clk,
    input logic     rst,
    pe_unit_if.unit u
);

    // Barrett reciprocals floor(2^shift / q)
    localparam int KEM_SHIFT = 24;
    localparam int DSA_SHIFT = 46;
    localparam logic [`PE_WIDTH-1:0] KEM_RECIP = 24'd5039;
    localparam logic [`PE_WIDTH-1:0] DSA_RECIP = 24'd8396807;
    localparam int EST_W = 3 * `PE_WIDTH;
    // Remainder before correction is below 3q
    localparam int REM_W = `PE_WIDTH + 1;

    pe_arith_pkg::product_t prod_r;
    logic                   dsa_p1;
    logic                   dsa_p2;
    logic [EST_W-1:0]       est;
    pe_arith_pkg::product_t quot;
    pe_arith_pkg::product_t q_wide;
    pe_arith_pkg::product_t rem_full;
    logic [REM_W-1:0]       rem_r;
    logic [REM_W-1:0]       q_ext;
    logic [REM_W-1:0]       fix1;
    logic [REM_W-1:0]       fix2;

    // Stage 1, full product
    always_ff @(posedge clk) begin
        if (rst) begin
            prod_r <= '0;
            dsa_p1 <= 1'b0;
        end else begin
            prod_r <= pe_arith_pkg::product_t'(u.mul_a) * pe_arith_pkg::product_t'(u.mul_b);
            dsa_p1 <= u.dsa;
        end
    end

    // Stage 2, subtract quotient estimate times q
    always_comb begin
        if (dsa_p1) begin
            est    = EST_W'(prod_r) * EST_W'(DSA_RECIP);
            quot   = pe_arith_pkg::product_t'(est >> DSA_SHIFT);
            q_wide = pe_arith_pkg::product_t'(pe_arith_pkg::Q_DSA);
        end else begin
            est    = EST_W'(prod_r) * EST_W'(KEM_RECIP);
            quot   = pe_arith_pkg::product_t'(est >> KEM_SHIFT);
            q_wide = pe_arith_pkg::product_t'(pe_arith_pkg::Q_KEM);
        end
        rem_full = prod_r - quot * q_wide;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rem_r  <= '0;
            dsa_p2 <= 1'b0;
        end else begin
            rem_r  <= rem_full[REM_W-1:0];
            dsa_p2 <= dsa_p1;
        end
    end

    // Stage 3, final correction
    always_comb begin
        q_ext = dsa_p2 ? {1'b0, pe_arith_pkg::Q_DSA} : {1'b0, pe_arith_pkg::Q_KEM};
        fix1  = (rem_r >= q_ext) ? rem_r - q_ext : rem_r;
        fix2  = (fix1 >= q_ext) ? fix1 - q_ext : fix1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            u.prod <= '0;
        end else begin
            u.prod <= fix2[`PE_WIDTH-1:0];
        end
    end

endmodule

//--- pe/mod_addsub_unit.sv
// --------------------
// Modular add/sub unit
// --------------------
`include "pe_settings.svh"
`timescale 1ns/10ps

module mod_addsub_unit (
    input logic     clk,
    input logic     rst,
    pe_unit_if.unit u
);

    pe_arith_pkg::coeff_t q;
    logic [`PE_WIDTH:0]   sum_raw;
    logic [`PE_WIDTH:0]   sum_red;
    logic [`PE_WIDTH:0]   diff_raw;
    pe_arith_pkg::coeff_t sum_nxt;
    pe_arith_pkg::coeff_t diff_nxt;

    assign q = u.dsa ? pe_arith_pkg::Q_DSA : pe_arith_pkg::Q_KEM;

    always_comb begin
        sum_raw  = {1'b0, u.add_a} + {1'b0, u.add_b};
        sum_red  = sum_raw - {1'b0, q};
        sum_nxt  = (sum_raw >= {1'b0, q}) ? sum_red[`PE_WIDTH-1:0] : sum_raw[`PE_WIDTH-1:0];
        // Top bit set means the difference borrowed
        diff_raw = {1'b0, u.sub_a} - {1'b0, u.sub_b};
        diff_nxt = diff_raw[`PE_WIDTH] ? diff_raw[`PE_WIDTH-1:0] + q : diff_raw[`PE_WIDTH-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            u.sum  <= '0;
            u.diff <= '0;
        end else begin
            u.sum  <= sum_nxt;
            u.diff <= diff_nxt;
        end
    end

endmodule

//--- logic/pe_delay_line.sv
// --------------------
// Coefficient delay
// --------------------
`timescale 1ns/10ps

module pe_delay_line #(
    parameter int DEPTH = 1
) (
    input  logic                 clk,
    input  logic                 rst,
    input  pe_arith_pkg::coeff_t din,
    output pe_arith_pkg::coeff_t dout
);

    pe_arith_pkg::coeff_t taps [0:DEPTH-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                taps[i] <= '0;
            end
        end else begin
            taps[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                taps[i] <= taps[i-1];
            end
        end
    end

    assign dout = taps[DEPTH-1];

endmodule

//--- common/pe_unit_if.sv
// --------------------
// Lane to unit link
// --------------------
`timescale 1ns/10ps

interface pe_unit_if;

    // Modulus select, 1 for the DSA prime
    logic                 dsa;
    pe_arith_pkg::coeff_t add_a;
    pe_arith_pkg::coeff_t add_b;
    pe_arith_pkg::coeff_t sub_a;
    pe_arith_pkg::coeff_t sub_b;
    pe_arith_pkg::coeff_t mul_a;
    pe_arith_pkg::coeff_t mul_b;

    // Registered results
    pe_arith_pkg::coeff_t sum;
    pe_arith_pkg::coeff_t diff;
    pe_arith_pkg::coeff_t prod;

    modport lane (
        output dsa, add_a, add_b, sub_a, sub_b, mul_a, mul_b,
        input  sum, diff, prod
    );

    modport unit (
        input  dsa, add_a, add_b, sub_a, sub_b, mul_a, mul_b,
        output sum, diff, prod
    );

endinterface

//--- common/pe_arith_pkg.sv
// --------------------
// PE arithmetic types
// --------------------
`include "pe_settings.svh"

package pe_arith_pkg;

    typedef logic [`PE_WIDTH-1:0]   coeff_t;
    typedef logic [2*`PE_WIDTH-1:0] product_t;

    localparam coeff_t Q_KEM = 24'd3329;
    localparam coeff_t Q_DSA = 24'd8380417;

    function automatic logic is_dsa(pe_ctrl_pkg::pe_alg_t alg);
        case (alg)
            pe_ctrl_pkg::DSA_44,
            pe_ctrl_pkg::DSA_65,
            pe_ctrl_pkg::DSA_87: begin
                return 1'b1;
            end
            default: begin
                return 1'b0;
            end
        endcase
    endfunction

    function automatic coeff_t modulus_of(pe_ctrl_pkg::pe_alg_t alg);
        if (is_dsa(alg)) begin
            return Q_DSA;
        end
        return Q_KEM;
    endfunction

endpackage

//--- common/pe_ctrl_pkg.sv
// --------------------
// PE control types
// --------------------
package pe_ctrl_pkg;

    // Encodings match the full instruction set
    typedef enum logic [4:0] {
        MADD   = 5'd0,
        MSUB   = 5'd1,
        MMUL   = 5'd2,
        CT_BFO = 5'd6,
        GS_BFO = 5'd7
    } pe_instr_t;

    typedef enum logic [4:0] {
        KEM_512  = 5'd0,
        KEM_768  = 5'd1,
        KEM_1024 = 5'd2,
        DSA_44   = 5'd3,
        DSA_65   = 5'd4,
        DSA_87   = 5'd5
    } pe_alg_t;

    // Cycles from data_in to data_out
    localparam int ADDSUB_LAT = 1;
    localparam int MUL_LAT    = 3;
    localparam int BFO_LAT    = 4;

endpackage

//--- common/pe_settings.svh
// --------------------
// PE array sizes
// --------------------
`ifndef PE_SETTINGS_SVH
`define PE_SETTINGS_SVH

// Lanes in the array
`define PE_NUM 4
// Coefficient width
`define PE_WIDTH 24
// Ports per lane
`define PE_IN_NUM 3
`define PE_OUT_NUM 2

`endif
